// ==== source/frodo_pkg.sv ====
// Frodo sampler definitions: lane geometry, table select and CDF thresholds for the lanes
package frodo_pkg;

  localparam int LANE_W = 16;
  localparam int LANES  = 4;

  typedef enum logic [1:0] {
    MODE_F640  = 2'd0,
    MODE_F976  = 2'd1,
    MODE_F1344 = 2'd2
  } sample_mode_e;

  localparam logic [14:0] CDF_F640 [12] = '{
    15'd4643, 15'd13363, 15'd20579, 15'd25843, 15'd29227, 15'd31145,
    15'd32103, 15'd32525, 15'd32689, 15'd32745, 15'd32762, 15'd32766
  };
  localparam logic [14:0] CDF_F976 [10] = '{
    15'd5638, 15'd15915, 15'd23689, 15'd28571, 15'd31116,
    15'd32217, 15'd32613, 15'd32731, 15'd32760, 15'd32766
  };
  localparam logic [14:0] CDF_F1344 [6] = '{
    15'd9142, 15'd23462, 15'd30338, 15'd32361, 15'd32725, 15'd32765
  };

  // past the table end every value is covered
  function automatic logic [14:0] cdf_threshold(input sample_mode_e mode,
                                                input logic [3:0] idx);
    logic [14:0] t;
    t = '1;
    case (mode)
      MODE_F640:  if (idx < 4'd12) t = CDF_F640[idx];
      MODE_F976:  if (idx < 4'd10) t = CDF_F976[idx];
      MODE_F1344: if (idx < 4'd6) t = CDF_F1344[idx[2:0]];
      default:    t = '1;
    endcase
    return t;
  endfunction

endpackage

// ==== source/adapter_pkg.sv ====
// Stream and command formats shared by the absorb and squeeze stages of the adapter
package adapter_pkg;

  localparam int WORD_W = 64;

  typedef enum logic [1:0] {
    OP_SEND_BYTE  = 2'd0,
    OP_SEND_ZEROS = 2'd1,
    OP_FORWARD    = 2'd2
  } absorb_op_e;

  typedef struct packed {
    logic [7:0] byte_val;  // byte, or zero-word count minus one
    logic       skip_last;
    absorb_op_e op;
  } absorb_cmd_t;

  typedef struct packed {
    logic skip_last;
    logic sample;  // run words through the CDF lanes
  } squeeze_cmd_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;
  } host_beat_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              single_byte;
    logic              last;
  } core_beat_t;

endpackage

// ==== source/cmd_fifo.sv ====
// Small circular command buffer that presents its head entry to a stage controller
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  output logic             o_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_has_any,
  input  logic             i_consume
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_ready   = (count != CNT_W'(DEPTH));
  assign o_has_any = (count != '0);
  assign o_data    = mem[rd_ptr];
  assign push      = i_valid & o_ready;
  assign pop       = i_consume & o_has_any;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push with pop
      endcase
    end
  end

endmodule

// ==== source/cdf_sampler_lane.sv ====
// One sampling lane: maps a 16-bit uniform value to a signed Frodo error sample
`timescale 1ns/1ps

module cdf_sampler_lane (
  input  frodo_pkg::sample_mode_e        i_mode,
  input  logic [frodo_pkg::LANE_W-1:0]   i_word,
  output logic [frodo_pkg::LANE_W-1:0]   o_sample
);
  import frodo_pkg::*;

  localparam int MAX_LEN = 12;  // longest table

  logic [LANE_W-2:0] val;
  logic              neg;
  logic [3:0]        mag;

  assign val = i_word[LANE_W-1:1];
  assign neg = i_word[0];

  // descending scan so the lowest matching index wins
  always_comb begin
    mag = 4'(MAX_LEN);
    for (int i = MAX_LEN - 1; i >= 0; i--) begin
      if (val <= cdf_threshold(i_mode, 4'(i))) begin
        mag = 4'(i);
      end
    end
  end

  // negative zero folds to zero
  assign o_sample = neg ? -LANE_W'(mag) : LANE_W'(mag);

endmodule

// ==== source/absorb_formatter.sv ====
// Absorb stage: turns queued byte, zero-run and forward commands into core input beats
`timescale 1ns/1ps

module absorb_formatter #(
  parameter int CMD_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  adapter_pkg::absorb_cmd_t i_cmd,
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_ready,
  input  adapter_pkg::host_beat_t  i_host_beat,
  input  logic                     i_host_valid,
  output logic                     o_host_ready,
  output adapter_pkg::core_beat_t  o_core_beat,
  output logic                     o_core_valid,
  input  logic                     i_core_ready
);
  import adapter_pkg::*;

  absorb_cmd_t head;
  logic        head_valid;
  logic        consume;
  logic        is_byte;
  logic        is_zeros;
  logic        is_fwd;
  logic        zero_busy;
  logic [7:0]  zero_left;
  logic [7:0]  zero_remain;
  logic        zero_final;
  logic        cmd_final;
  logic        core_xfer;

  cmd_fifo #(
    .WIDTH($bits(absorb_cmd_t)),
    .DEPTH(CMD_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_data    (i_cmd),
    .i_valid   (i_cmd_valid),
    .o_ready   (o_cmd_ready),
    .o_data    (head),
    .o_has_any (head_valid),
    .i_consume (consume)
  );

  assign is_byte  = head_valid & (head.op == OP_SEND_BYTE);
  assign is_zeros = head_valid & (head.op == OP_SEND_ZEROS);
  assign is_fwd   = head_valid & (head.op == OP_FORWARD);

  // beats still owed after the current one
  assign zero_remain = zero_busy ? zero_left : head.byte_val;
  assign zero_final  = (zero_remain == '0);

  assign o_core_valid = is_byte | is_zeros | (is_fwd & i_host_valid);
  assign o_host_ready = is_fwd & i_core_ready;
  assign core_xfer    = o_core_valid & i_core_ready;

  assign cmd_final = is_byte | (is_zeros & zero_final) | (is_fwd & i_host_beat.last);
  assign consume   = core_xfer & cmd_final;

  always_comb begin
    o_core_beat.data        = '0;  // zero run
    if (is_byte) begin
      o_core_beat.data = {{(WORD_W - 8){1'b0}}, head.byte_val};
    end else if (is_fwd) begin
      o_core_beat.data = i_host_beat.data;
    end
    o_core_beat.single_byte = is_byte;
    o_core_beat.last        = cmd_final & ~head.skip_last;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      zero_busy <= 1'b0;
      zero_left <= '0;
    end else if (is_zeros && core_xfer) begin
      if (zero_final) begin
        zero_busy <= 1'b0;
      end else begin
        zero_busy <= 1'b1;
        zero_left <= zero_remain - 1'b1;
      end
    end
  end

endmodule

// ==== source/squeeze_sampler.sv ====
// Squeeze stage: forwards core output words to the host, raw or through four CDF lanes
`timescale 1ns/1ps

module squeeze_sampler #(
  parameter int CMD_DEPTH = 3
) (
  input  logic                             clk,
  input  logic                             i_rst_n,
  input  adapter_pkg::squeeze_cmd_t        i_cmd,
  input  logic                             i_cmd_valid,
  output logic                             o_cmd_ready,
  input  frodo_pkg::sample_mode_e          i_mode,
  input  logic [adapter_pkg::WORD_W-1:0]   i_core_data,
  input  logic                             i_core_valid,
  output logic                             o_core_ready,
  output logic                             o_core_last,
  output logic [adapter_pkg::WORD_W-1:0]   o_host_data,
  output logic                             o_host_valid,
  input  logic                             i_host_ready,
  input  logic                             i_host_last
);
  import adapter_pkg::*;
  import frodo_pkg::*;

  squeeze_cmd_t      head;
  logic              head_valid;
  logic              done;
  logic [WORD_W-1:0] sampled;

  cmd_fifo #(
    .WIDTH($bits(squeeze_cmd_t)),
    .DEPTH(CMD_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_data    (i_cmd),
    .i_valid   (i_cmd_valid),
    .o_ready   (o_cmd_ready),
    .o_data    (head),
    .o_has_any (head_valid),
    .i_consume (done)
  );

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    cdf_sampler_lane u_lane (
      .i_mode   (i_mode),
      .i_word   (i_core_data[g*LANE_W +: LANE_W]),
      .o_sample (sampled[g*LANE_W +: LANE_W])
    );
  end

  assign o_host_valid = head_valid & i_core_valid;
  assign o_core_ready = head_valid & i_host_ready;
  assign o_host_data  = head.sample ? sampled : i_core_data;

  assign done        = o_host_valid & i_host_ready & i_host_last;  // host ends the command
  assign o_core_last = done & ~head.skip_last;

endmodule

// ==== source/keccak_adapter.sv ====
// Top level of the Keccak adapter: absorb and squeeze stages around an external core
`timescale 1ns/1ps

module keccak_adapter #(
  parameter int ABSORB_CMD_DEPTH  = 4,
  parameter int SQUEEZE_CMD_DEPTH = 3
) (
  input  logic                             clk,
  input  logic                             i_rst_n,
  input  frodo_pkg::sample_mode_e          i_mode,
  // command queues
  input  adapter_pkg::absorb_cmd_t         i_absorb_cmd,
  input  logic                             i_absorb_cmd_valid,
  output logic                             o_absorb_cmd_ready,
  input  adapter_pkg::squeeze_cmd_t        i_squeeze_cmd,
  input  logic                             i_squeeze_cmd_valid,
  output logic                             o_squeeze_cmd_ready,
  // host to core
  input  adapter_pkg::host_beat_t          i_host_beat,
  input  logic                             i_host_valid,
  output logic                             o_host_ready,
  output adapter_pkg::core_beat_t          o_core_in_beat,
  output logic                             o_core_in_valid,
  input  logic                             i_core_in_ready,
  // core to host
  input  logic [adapter_pkg::WORD_W-1:0]   i_core_out_data,
  input  logic                             i_core_out_valid,
  output logic                             o_core_out_ready,
  output logic                             o_core_out_last,
  output logic [adapter_pkg::WORD_W-1:0]   o_host_data,
  output logic                             o_host_valid,
  input  logic                             i_host_ready,
  input  logic                             i_host_last
);

  absorb_formatter #(
    .CMD_DEPTH(ABSORB_CMD_DEPTH)
  ) u_absorb (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cmd        (i_absorb_cmd),
    .i_cmd_valid  (i_absorb_cmd_valid),
    .o_cmd_ready  (o_absorb_cmd_ready),
    .i_host_beat  (i_host_beat),
    .i_host_valid (i_host_valid),
    .o_host_ready (o_host_ready),
    .o_core_beat  (o_core_in_beat),
    .o_core_valid (o_core_in_valid),
    .i_core_ready (i_core_in_ready)
  );

  squeeze_sampler #(
    .CMD_DEPTH(SQUEEZE_CMD_DEPTH)
  ) u_squeeze (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cmd        (i_squeeze_cmd),
    .i_cmd_valid  (i_squeeze_cmd_valid),
    .o_cmd_ready  (o_squeeze_cmd_ready),
    .i_mode       (i_mode),
    .i_core_data  (i_core_out_data),
    .i_core_valid (i_core_out_valid),
    .o_core_ready (o_core_out_ready),
    .o_core_last  (o_core_out_last),
    .o_host_data  (o_host_data),
    .o_host_valid (o_host_valid),
    .i_host_ready (i_host_ready),
    .i_host_last  (i_host_last)
  );

endmodule

// ==== bench/keccak_adapter_asserts.sv ====
// Protocol assertions on the adapter output streams, bound into every keccak_adapter instance
`timescale 1ns/1ps

module keccak_adapter_asserts (
  input logic                           clk,
  input logic                           i_rst_n,
  input adapter_pkg::core_beat_t        o_core_in_beat,
  input logic                           o_core_in_valid,
  input logic [adapter_pkg::WORD_W-1:0] o_host_data,
  input logic                           o_host_valid,
  input logic                           i_host_ready
);
  import adapter_pkg::*;

  a_reset_quiet: assert property (@(posedge clk) !i_rst_n |-> !o_core_in_valid && !o_host_valid)
    else $error("valid output high during reset");

  // a lone byte carries nothing above bit 7
  a_byte_upper_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_core_in_valid && o_core_in_beat.single_byte |-> o_core_in_beat.data[WORD_W-1:8] == '0)
    else $error("single byte beat with upper data bits set");

  a_host_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_host_valid && !i_host_ready |=> o_host_valid && $stable(o_host_data))
    else $error("squeeze beat changed while the host stalled");

endmodule

bind keccak_adapter keccak_adapter_asserts u_asserts (.*);

// ==== bench/keccak_adapter_checker.sv ====
// Testbench monitor: models both adapter stages from accepted commands and checks every beat
`timescale 1ns/1ps

module keccak_adapter_checker #(
  parameter int ABSORB_CMD_DEPTH  = 4,
  parameter int SQUEEZE_CMD_DEPTH = 3
) (
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  frodo_pkg::sample_mode_e        i_mode,
  input  adapter_pkg::absorb_cmd_t       i_absorb_cmd,
  input  logic                           i_absorb_cmd_valid, o_absorb_cmd_ready,
  input  adapter_pkg::squeeze_cmd_t      i_squeeze_cmd,
  input  logic                           i_squeeze_cmd_valid, o_squeeze_cmd_ready,
  input  adapter_pkg::host_beat_t        i_host_beat,
  input  logic                           i_host_valid, o_host_ready,
  input  adapter_pkg::core_beat_t        o_core_in_beat,
  input  logic                           o_core_in_valid, i_core_in_ready,
  input  logic [adapter_pkg::WORD_W-1:0] i_core_out_data, o_host_data,
  input  logic                           i_core_out_valid, o_core_out_ready, o_core_out_last,
  input  logic                           o_host_valid, i_host_ready, i_host_last,
  output int                             o_errors, o_abs_retired, o_sqz_retired
);
  import adapter_pkg::*;
  import frodo_pkg::*;

  localparam int CMP_W = WORD_W + 2;

  absorb_cmd_t  abs_q[$];
  squeeze_cmd_t sqz_q[$];
  int           zero_cnt;  // zero beats of the head command seen so far

  // walk up the table until a threshold covers the value
  function automatic logic [LANE_W-1:0] expect_sample(input sample_mode_e mode,
                                                      input logic [LANE_W-1:0] w);
    int mag;
    mag = 0;
    while (w[LANE_W-1:1] > cdf_threshold(mode, 4'(mag))) mag++;
    return w[0] ? LANE_W'(-mag) : LANE_W'(mag);
  endfunction

  function automatic logic [WORD_W-1:0] expect_word(input sample_mode_e mode,
                                                    input logic [WORD_W-1:0] w);
    logic [WORD_W-1:0] r;
    for (int l = 0; l < LANES; l++) begin
      r[l*LANE_W +: LANE_W] = expect_sample(mode, w[l*LANE_W +: LANE_W]);
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [CMP_W-1:0] got, want);
    if (got !== want) begin
      o_errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic report_fault(input string what);
    o_errors++;
    $display("error: %s at %0t", what, $time);
  endtask

  // judged mid-cycle, once sources and outputs have settled
  always @(negedge clk) begin
    core_beat_t   want;
    squeeze_cmd_t sc;
    logic         core_take;
    logic         host_take;
    logic         out_take;
    logic         fwd_head;
    logic         fin;
    if (!i_rst_n) begin
      abs_q.delete();
      sqz_q.delete();
      zero_cnt = 0;
    end else begin
      // buffers refuse only when the model holds a full depth of commands
      compare("o_absorb_cmd_ready", CMP_W'(o_absorb_cmd_ready),
              CMP_W'(abs_q.size() < ABSORB_CMD_DEPTH));
      compare("o_squeeze_cmd_ready", CMP_W'(o_squeeze_cmd_ready),
              CMP_W'(sqz_q.size() < SQUEEZE_CMD_DEPTH));
      core_take = o_core_in_valid & i_core_in_ready;
      host_take = i_host_valid & o_host_ready;
      out_take  = o_host_valid & i_host_ready;
      fwd_head  = (abs_q.size() != 0) && (abs_q[0].op == OP_FORWARD);
      if (o_core_in_valid && abs_q.size() == 0)
        report_fault("core input valid with no absorb command pending");
      if (host_take != (core_take && fwd_head))
        report_fault("host and core input transfers out of step");
      if (core_take && abs_q.size() != 0) begin
        want = '0;
        fin  = 1'b1;
        case (abs_q[0].op)
          OP_SEND_BYTE: begin
            want.data        = WORD_W'(abs_q[0].byte_val);
            want.single_byte = 1'b1;
          end
          OP_SEND_ZEROS: begin
            fin      = (zero_cnt == int'(abs_q[0].byte_val));
            zero_cnt = fin ? 0 : zero_cnt + 1;
          end
          default: begin
            want.data = i_host_beat.data;
            fin       = i_host_beat.last;
          end
        endcase
        want.last = fin & ~abs_q[0].skip_last;
        compare("o_core_in_beat", o_core_in_beat, want);
        if (fin) begin
          void'(abs_q.pop_front());
          o_abs_retired++;
        end
      end
      if (o_host_valid && sqz_q.size() == 0)
        report_fault("host output valid with no squeeze command pending");
      if (out_take != (i_core_out_valid && o_core_out_ready))
        report_fault("core output and host transfers out of step");
      if (out_take && sqz_q.size() != 0) begin
        sc = sqz_q[0];
        compare("o_host_data", CMP_W'(o_host_data),
                CMP_W'(sc.sample ? expect_word(i_mode, i_core_out_data) : i_core_out_data));
        compare("o_core_out_last", CMP_W'(o_core_out_last), CMP_W'(i_host_last & ~sc.skip_last));
        if (i_host_last) begin
          void'(sqz_q.pop_front());
          o_sqz_retired++;
        end
      end else if (o_core_out_last) begin
        report_fault("core output last raised without a host last transfer");
      end
      // commands land in the model after this cycle's beats
      if (i_absorb_cmd_valid && o_absorb_cmd_ready) abs_q.push_back(i_absorb_cmd);
      if (i_squeeze_cmd_valid && o_squeeze_cmd_ready) sqz_q.push_back(i_squeeze_cmd);
    end
  end

endmodule

// ==== bench/keccak_adapter_tb.sv ====
// Testbench top for keccak_adapter: clock, reset, seeded random sources and sinks, verdict
`timescale 1ns/1ps

module keccak_adapter_tb;
  import adapter_pkg::*;
  import frodo_pkg::*;

  localparam int N_ABSORB          = 40;
  localparam int N_SQUEEZE         = 40;
  localparam int PERIOD            = 100;
  localparam int ABSORB_CMD_DEPTH  = 4;
  localparam int SQUEEZE_CMD_DEPTH = 3;

  logic              clk;
  logic              i_rst_n;
  sample_mode_e      i_mode;
  absorb_cmd_t       i_absorb_cmd;
  logic              i_absorb_cmd_valid, o_absorb_cmd_ready;
  squeeze_cmd_t      i_squeeze_cmd;
  logic              i_squeeze_cmd_valid, o_squeeze_cmd_ready;
  host_beat_t        i_host_beat;
  logic              i_host_valid, o_host_ready;
  core_beat_t        o_core_in_beat;
  logic              o_core_in_valid, i_core_in_ready;
  logic [WORD_W-1:0] i_core_out_data, o_host_data;
  logic              i_core_out_valid, o_core_out_ready, o_core_out_last;
  logic              o_host_valid, i_host_ready, i_host_last;
  int                o_errors, o_abs_retired, o_sqz_retired;
  int                seed = 32'h3d8e_bdfb;
  int                abs_sent;
  int                sqz_sent;

  keccak_adapter #(
    .ABSORB_CMD_DEPTH (ABSORB_CMD_DEPTH),
    .SQUEEZE_CMD_DEPTH(SQUEEZE_CMD_DEPTH)
  ) dut_i (.*);

  keccak_adapter_checker #(
    .ABSORB_CMD_DEPTH (ABSORB_CMD_DEPTH),
    .SQUEEZE_CMD_DEPTH(SQUEEZE_CMD_DEPTH)
  ) chk_i (.*);

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [WORD_W-1:0] rand_word();
    return {32'($random(seed)), 32'($random(seed))};
  endfunction

  // handshakes read mid-cycle, fresh values 1 ns after the edge
  task automatic drive_sources();
    logic take_abs;
    logic take_sqz;
    logic take_host;
    logic take_core;
    @(negedge clk);
    take_abs  = i_absorb_cmd_valid & o_absorb_cmd_ready;
    take_sqz  = i_squeeze_cmd_valid & o_squeeze_cmd_ready;
    take_host = i_host_valid & o_host_ready;
    take_core = i_core_out_valid & o_core_out_ready;
    @(posedge clk);
    #1;
    if (take_abs) abs_sent++;
    if (take_sqz) sqz_sent++;
    if (take_abs || !i_absorb_cmd_valid) begin
      i_absorb_cmd.op        = absorb_op_e'(2'(rand_below(3)));
      i_absorb_cmd.skip_last = rand_below(2) == 1;
      i_absorb_cmd.byte_val  = (i_absorb_cmd.op == OP_SEND_ZEROS) ? 8'(rand_below(16))
                                                                  : 8'(rand_below(256));
      i_absorb_cmd_valid     = (abs_sent < N_ABSORB) && (rand_below(4) != 0);
    end
    if (take_sqz || !i_squeeze_cmd_valid) begin
      i_squeeze_cmd.skip_last = rand_below(2) == 1;
      i_squeeze_cmd.sample    = rand_below(2) == 1;
      i_squeeze_cmd_valid     = (sqz_sent < N_SQUEEZE) && (rand_below(4) != 0);
    end
    if (take_host || !i_host_valid) begin
      i_host_beat.data = rand_word();
      i_host_beat.last = rand_below(4) == 0;
      i_host_valid     = rand_below(4) != 0;
    end
    // mode only moves with a fresh core word
    if (take_core || !i_core_out_valid) begin
      i_core_out_data  = rand_word();
      i_core_out_valid = rand_below(4) != 0;
      i_mode           = sample_mode_e'(2'(rand_below(3)));
    end
    i_core_in_ready = rand_below(4) != 0;
    i_host_ready    = rand_below(3) != 0;
    i_host_last     = rand_below(4) == 0;
  endtask

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    i_rst_n             = 1'b0;
    i_mode              = MODE_F640;
    i_absorb_cmd        = '0;
    i_absorb_cmd_valid  = 1'b0;
    i_squeeze_cmd       = '0;
    i_squeeze_cmd_valid = 1'b0;
    i_host_beat         = '0;
    i_host_valid        = 1'b0;
    i_core_in_ready     = 1'b0;
    i_core_out_data     = '0;
    i_core_out_valid    = 1'b0;
    i_host_ready        = 1'b0;
    i_host_last         = 1'b0;
    abs_sent            = 0;
    sqz_sent            = 0;
    repeat (3) @(posedge clk);
    #1 i_rst_n = 1'b1;
    fork
      forever drive_sources();
    join_none
    wait (o_abs_retired == N_ABSORB && o_sqz_retired == N_SQUEEZE);
    repeat (4) @(posedge clk);
    $display("errors %0d, absorb commands %0d of %0d, squeeze commands %0d of %0d",
             o_errors, o_abs_retired, N_ABSORB, o_sqz_retired, N_SQUEEZE);
    if (o_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat ((N_ABSORB + N_SQUEEZE) * 200 + 1000) @(posedge clk);
    $display("watchdog expired with %0d absorb and %0d squeeze commands retired",
             o_abs_retired, o_sqz_retired);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== keccak_adapter.f ====
source/frodo_pkg.sv
source/adapter_pkg.sv
source/cmd_fifo.sv
source/cdf_sampler_lane.sv
source/absorb_formatter.sv
source/squeeze_sampler.sv
source/keccak_adapter.sv
bench/keccak_adapter_asserts.sv
bench/keccak_adapter_checker.sv
bench/keccak_adapter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the keccak_adapter testbench with Verilator; passes only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module keccak_adapter_tb -f keccak_adapter.f
out=$(./obj_dir/Vkeccak_adapter_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -q "All tests passed"
